//--- alu.sv
`timescale 1ns/100ps

module alu (
    input  logic [cpuPkg::xlen-1:0]  a,
    input  logic [cpuPkg::xlen-1:0]  b,
    input  cpuPkg::aluCtrlT          aluCtrl,
    output logic [cpuPkg::xlen-1:0]  result,
    output logic                     zero
);
    import cpuPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        case (aluCtrl)
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLT: begin
                result = {{(xlen - 1){1'b0}}, lessThan};
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // Drives the beq decision

endmodule

//--- controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  logic [cpuPkg::xlen-1:0]  inst,
    output logic                     regWrite,
    output logic                     aluSrc,
    output logic                     memWrite,
    output logic                     memToReg,
    output logic                     isBranch,
    output cpuPkg::immFmtT           immFmt,
    output cpuPkg::aluCtrlT          aluCtrl
);
    import cpuPkg::*;

    opcodeT     opcode;
    aluOpT      aluOp;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode   = opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    // Main decoder
    always_comb begin
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        isBranch = 1'b0;
        immFmt   = IMM_I;
        aluOp    = ALU_ADD_CLASS;
        case (opcode)
            OP_R: begin
                regWrite = 1'b1;
                aluOp    = ALU_FUNCT_CLASS;
            end
            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            OP_LOAD: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
            end
            OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immFmt   = IMM_S;
            end
            OP_BRANCH: begin
                isBranch = 1'b1;
                immFmt   = IMM_B;
                aluOp    = ALU_SUB_CLASS; // Compare by subtracting
            end
            default: ; // Behaves as a no-op
        endcase
    end

    // ALU decoder
    always_comb begin
        case (aluOp)
            ALU_SUB_CLASS: aluCtrl = ALU_SUB;
            ALU_FUNCT_CLASS: begin
                case (funct3)
                    3'b000:  aluCtrl = funct7b5 ? ALU_SUB : ALU_ADD;
                    3'b010:  aluCtrl = ALU_SLT;
                    3'b110:  aluCtrl = ALU_OR;
                    3'b111:  aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD;
                endcase
            end
            default: aluCtrl = ALU_ADD;
        endcase
    end

endmodule

//--- cpuPkg.sv
package cpuPkg;

    // Datapath and register index widths
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // RISC-V major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcodeT;

    // Coarse ALU class from the main decoder
    typedef enum logic [1:0] {
        ALU_ADD_CLASS   = 2'b00, // lw, sw, addi
        ALU_SUB_CLASS   = 2'b01, // beq compare
        ALU_FUNCT_CLASS = 2'b10  // R-type, look at funct fields
    } aluOpT;

    // ALU function select
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluCtrlT;

    // Immediate layouts handled by immGen
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10
    } immFmtT;

endpackage

//--- dataMem.sv
`timescale 1ns/100ps

module dataMem #(
    parameter int dataMemWords = 64
) (
    input  logic                     CLK,
    input  logic                     we,
    input  logic [cpuPkg::xlen-1:0]  addr,
    input  logic [cpuPkg::xlen-1:0]  wdata,
    output logic [cpuPkg::xlen-1:0]  rdata
);
    import cpuPkg::*;

    localparam int addrW = $clog2(dataMemWords);

    logic [xlen-1:0]  mem [dataMemWords];
    logic [xlen-3:0]  wordIdx;
    logic             inRange;

    assign wordIdx = addr[xlen-1:2]; // Byte address to word index
    assign inRange = (wordIdx < dataMemWords);

    always_ff @(posedge CLK) begin
        if (we && inRange) begin
            mem[wordIdx[addrW-1:0]] <= wdata;
        end
    end

    // Combinational read
    assign rdata = inRange ? mem[wordIdx[addrW-1:0]] : '0;

endmodule

//--- filelist.f
cpuPkg.sv
programCounter.sv
instMem.sv
registerFile.sv
immGen.sv
controlUnit.sv
alu.sv
dataMem.sv
singleCpu.sv
tbSingleCpu.sv

//--- immGen.sv
`timescale 1ns/100ps

module immGen (
    input  logic [cpuPkg::xlen-1:0]  inst,
    input  cpuPkg::immFmtT           immFmt,
    output logic [cpuPkg::xlen-1:0]  imm
);
    import cpuPkg::*;

    logic signBit;

    assign signBit = inst[31];

    always_comb begin
        case (immFmt)
            IMM_I: begin
                imm = {{20{signBit}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{20{signBit}}, inst[31:25], inst[11:7]}; // Split field
            end
            IMM_B: begin
                // Scrambled branch offset, LSB always zero
                imm = {{19{signBit}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- instMem.sv
`timescale 1ns/100ps

module instMem #(
    parameter int instMemWords = 64
) (
    input  logic                             CLK,
    input  logic                             loadEn,
    input  logic [$clog2(instMemWords)-1:0]  loadAddr,
    input  logic [cpuPkg::xlen-1:0]          loadData,
    input  logic [cpuPkg::xlen-1:0]          pc,
    output logic [cpuPkg::xlen-1:0]          inst
);
    import cpuPkg::*;

    localparam int addrW = $clog2(instMemWords);

    logic [xlen-1:0]  mem [instMemWords];
    logic [xlen-3:0]  wordIdx;
    logic             inRange;

    // Program load, word at a time
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign wordIdx = pc[xlen-1:2];
    assign inRange = (wordIdx < instMemWords);

    // Fetch is combinational
    always_comb begin
        if (inRange) begin
            inst = mem[wordIdx[addrW-1:0]];
        end else begin
            inst = '0; // Past the end
        end
    end

endmodule

//--- programCounter.sv
`timescale 1ns/100ps

module programCounter #(
    parameter int instMemWords = 64
) (
    input  logic                     CLK,
    input  logic                     rstN,
    input  logic                     run,
    input  logic [cpuPkg::xlen-1:0]  imm,
    input  logic                     branchTaken,
    output logic [cpuPkg::xlen-1:0]  pc
);
    import cpuPkg::*;

    // Only the bits that can address the instruction memory are kept
    localparam int pcW = $clog2(instMemWords) + 2;

    logic [pcW-1:0]  pcReg;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] nextPc;

    assign pc           = {{(xlen - pcW){1'b0}}, pcReg};
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm; // imm is already a byte offset
    assign nextPc       = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;
        end else if (run) begin
            pcReg <= nextPc[pcW-1:0];
        end
    end

endmodule

//--- registerFile.sv
`timescale 1ns/100ps

module registerFile (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         we,
    input  logic [cpuPkg::regAddrW-1:0]  rs1,
    input  logic [cpuPkg::regAddrW-1:0]  rs2,
    input  logic [cpuPkg::regAddrW-1:0]  rd,
    input  logic [cpuPkg::xlen-1:0]      wd,
    output logic [cpuPkg::xlen-1:0]      rd1,
    output logic [cpuPkg::xlen-1:0]      rd2
);
    import cpuPkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 stays zero
            regs[rd] <= wd;
        end
    end

    // Two read ports, x0 hardwired
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the single-cycle core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tbSingleCpu -o simSingleCpu \
    && ./obj_dir/simSingleCpu > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

//--- singleCpu.sv
`timescale 1ns/100ps

module singleCpu #(
    parameter int instMemWords = 64,
    parameter int dataMemWords = 64
) (
    input  logic                             CLK,
    input  logic                             rstN,
    input  logic                             run,
    input  logic                             loadEn,
    input  logic [$clog2(instMemWords)-1:0]  loadAddr,
    input  logic [cpuPkg::xlen-1:0]          loadData,
    output logic [cpuPkg::xlen-1:0]          pc,
    output logic                             wbValid,
    output logic [cpuPkg::regAddrW-1:0]      wbReg,
    output logic [cpuPkg::xlen-1:0]          wbData
);
    import cpuPkg::*;

    logic [xlen-1:0]     inst;
    logic [xlen-1:0]     rd1;
    logic [xlen-1:0]     rd2;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     aluB;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     memRdata;
    logic [regAddrW-1:0] rd;
    logic                zero;
    logic                regWrite;
    logic                aluSrc;
    logic                memWrite;
    logic                memToReg;
    logic                isBranch;
    logic                branchTaken;
    immFmtT              immFmt;
    aluCtrlT             aluCtrl;

    assign rd          = inst[11:7];
    assign aluB        = aluSrc ? imm : rd2; // Immediate or rs2
    assign branchTaken = isBranch & zero;
    assign wbData      = memToReg ? memRdata : aluResult;
    assign wbReg       = rd;
    assign wbValid     = regWrite & run & (rd != '0);

    programCounter #(.instMemWords(instMemWords)) pcUnit (
        .CLK(CLK), .rstN(rstN), .run(run),
        .imm(imm), .branchTaken(branchTaken), .pc(pc)
    );

    // Loading only while halted
    instMem #(.instMemWords(instMemWords)) iMem (
        .CLK(CLK), .loadEn(loadEn & ~run), .loadAddr(loadAddr),
        .loadData(loadData), .pc(pc), .inst(inst)
    );

    controlUnit ctrl (
        .inst(inst), .regWrite(regWrite), .aluSrc(aluSrc), .memWrite(memWrite),
        .memToReg(memToReg), .isBranch(isBranch), .immFmt(immFmt), .aluCtrl(aluCtrl)
    );

    registerFile regs (
        .CLK(CLK), .rstN(rstN), .we(wbValid),
        .rs1(inst[19:15]), .rs2(inst[24:20]), .rd(rd), .wd(wbData),
        .rd1(rd1), .rd2(rd2)
    );

    immGen immUnit (.inst(inst), .immFmt(immFmt), .imm(imm));

    alu aluUnit (
        .a(rd1), .b(aluB), .aluCtrl(aluCtrl), .result(aluResult), .zero(zero)
    );

    dataMem #(.dataMemWords(dataMemWords)) dMem (
        .CLK(CLK), .we(memWrite & run), .addr(aluResult),
        .wdata(rd2), .rdata(memRdata)
    );

endmodule

//--- tbSingleCpu.sv
`timescale 1ns/100ps

module tbSingleCpu;
    import cpuPkg::*;

    localparam int instMemWords = 64;
    localparam int dataMemWords = 64;
    localparam int traceTimeout = 500; // Cycles for the whole trace
    localparam int endWait      = 20;
    localparam int quietCycles  = 10;

    logic                            CLK;
    logic                            rstN;
    logic                            run;
    logic                            loadEn;
    logic [$clog2(instMemWords)-1:0] loadAddr;
    logic [xlen-1:0]                 loadData;
    logic [xlen-1:0]                 pc;
    logic                            wbValid;
    logic [regAddrW-1:0]             wbReg;
    logic [xlen-1:0]                 wbData;

    logic [31:0]         testData [256];
    logic [regAddrW-1:0] expReg [64];
    logic [xlen-1:0]     expData [64];
    logic [xlen-1:0]     expPc;
    int                  progLen;
    int                  expCount;
    int                  wbIdx;
    int                  testErrors [1:6];
    int                  sliceEnd [2:5]; // Trace index where each test stops
    int                  testsPassed;
    int                  testsFailed;

    singleCpu #(.instMemWords(instMemWords), .dataMemWords(dataMemWords)) dut (
        .CLK(CLK), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .pc(pc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    always #2 CLK = ~CLK;

    function automatic string testName(input int num);
        case (num)
            1:       return "reset state";
            2:       return "arithmetic and logic";
            3:       return "memory round trip";
            4:       return "branches";
            5:       return "register x0";
            default: return "termination";
        endcase
    endfunction

    // Test that owns a trace entry
    function automatic int testOfEntry(input int idx);
        int num;
        num = 5;
        for (int t = 5; t >= 2; t--) begin
            if (idx < sliceEnd[t]) begin
                num = t;
            end
        end
        return num;
    endfunction

    task automatic reportTest(input int num);
        if (testErrors[num] == 0) begin
            testsPassed++;
            $display("Test %0d %s: passed", num, testName(num));
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed, %0d errors", num, testName(num), testErrors[num]);
        end
    endtask

    // Halted core sits at pc 0 with no writeback
    task automatic expectIdle();
        if (pc !== '0) begin
            $display("[ERROR] pc exp %h got %h", 32'h0, pc);
            testErrors[1]++;
        end
        if (wbValid !== 1'b0) begin
            $display("[ERROR] wbValid exp %h got %h", 1'b0, wbValid);
            testErrors[1]++;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            loadEn   <= 1'b1;
            loadAddr <= i[$clog2(instMemWords)-1:0];
            loadData <= testData[1 + i];
            @(negedge CLK);
            expectIdle();
        end
    endtask

    task automatic compareWriteback(input int idx);
        int num;
        num = testOfEntry(idx);
        if (wbReg !== expReg[idx]) begin
            $display("[ERROR] wbReg exp %h got %h at entry %0d", expReg[idx], wbReg, idx);
            testErrors[num]++;
        end
        if (wbData !== expData[idx]) begin
            $display("[ERROR] wbData exp %h got %h at entry %0d", expData[idx], wbData, idx);
            testErrors[num]++;
        end
    endtask

    // Self-loop reached, then nothing more may happen
    task automatic watchEndLoop();
        int waited;
        waited = 0;
        while (pc !== expPc && waited < endWait) begin
            @(negedge CLK);
            waited++;
        end
        if (pc !== expPc) begin
            $display("Core did not reach the final pc within %0d cycles", endWait);
            testErrors[6]++;
        end
        for (int c = 0; c < quietCycles; c++) begin
            @(negedge CLK);
            if (pc !== expPc) begin
                $display("[ERROR] pc exp %h got %h", expPc, pc);
                testErrors[6]++;
            end
            if (wbValid !== 1'b0) begin
                $display("Unexpected writeback to x%0d after the trace ended", wbReg);
                testErrors[6]++;
            end
        end
    endtask

    initial begin
        CLK         = 1'b0;
        rstN        = 1'b0;
        run         = 1'b0;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        testsPassed = 0;
        testsFailed = 0;
        wbIdx       = 0;
        for (int t = 1; t <= 6; t++) begin
            testErrors[t] = 0;
        end
        sliceEnd[2] = 8;
        sliceEnd[3] = 10;
        sliceEnd[4] = 11;
        sliceEnd[5] = 12;

        $readmemh("testdata.hex", testData);
        progLen  = testData[0];
        expCount = testData[progLen + 1];
        for (int k = 0; k < expCount; k++) begin
            expReg[k]  = testData[progLen + 2 + 2 * k][regAddrW-1:0];
            expData[k] = testData[progLen + 3 + 2 * k];
        end
        expPc = testData[progLen + 2 + 2 * expCount];

        repeat (2) @(posedge CLK);
        rstN <= 1'b1;

        loadProgram();
        reportTest(1);
        @(posedge CLK);
        loadEn <= 1'b0;
        run    <= 1'b1;

        // Follow the writeback trace
        for (int c = 0; c < traceTimeout && wbIdx < expCount; c++) begin
            @(negedge CLK);
            if (wbValid === 1'b1) begin
                compareWriteback(wbIdx);
                wbIdx++;
                for (int t = 2; t <= 5; t++) begin
                    if (wbIdx == sliceEnd[t]) begin
                        reportTest(t);
                    end
                end
            end
        end

        if (wbIdx < expCount) begin
            $display("Timeout: %0d of %0d writebacks seen in %0d cycles",
                     wbIdx, expCount, traceTimeout);
            for (int t = 2; t <= 5; t++) begin
                if (wbIdx < sliceEnd[t]) begin
                    testErrors[t]++;
                    reportTest(t);
                end
            end
            testErrors[6]++;
        end else begin
            watchEndLoop();
        end
        reportTest(6);

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- testdata.hex
// Program length, program words, writeback count,
// then pairs of register number and value, then the final pc
13
// addi x1,x0,6 and addi x2,x0,-3
00600093
FFD00113
// add, sub, and, or, slt x7, slt x8
002081B3
40208233
0020F2B3
0020E333
001123B3
0020A433
// sw x1,0(x0) and sw x6,8(x0)
00102023
00602423
// lw x9,0(x0) and lw x10,8(x0)
00002483
00802503
// beq x1,x1 taken over addi x11, then beq x1,x2 falls into addi x12
00108463
00100593
00208463
00700613
// addi x0 is dropped, add x13 reads x0
00900013
00C006B3
// End loop
00000063
// Writeback count
0C
01
00000006
02
FFFFFFFD
03
00000003
04
00000009
05
00000004
06
FFFFFFFF
07
00000001
08
00000000
09
00000006
0A
FFFFFFFF
0C
00000007
0D
00000007
// Final pc
00000048
